// File: design/dcache_pkg.sv
package dcache_pkg;

        localparam int TAG_W = 26;
        localparam int IDX_W = 3;

        typedef logic [31:0] word_t;

        // byte_off picks the byte within the word
        typedef struct packed {
                logic [TAG_W-1:0] tag;
                logic [IDX_W-1:0] idx;
                logic             blk;
                logic [1:0]       byte_off;
        } addr_t;

        typedef struct packed {
                logic             valid;
                logic             dirty;
                logic [TAG_W-1:0] tag;
        } tag_entry_t;

        typedef struct packed {
                word_t word1;
                word_t word0;
        } block_t;

        typedef struct packed {
                logic  ren;
                logic  wen;
                addr_t addr;
                word_t store;
        } dp_req_t;

        typedef struct packed {
                logic  ren;
                logic  wen;
                word_t addr;
                word_t store;
        } mem_req_t;

        typedef enum logic [3:0] {
                IDLE,
                WB0,
                WB1,
                FILL0,
                FILL1,
                FLUSH_CHK,
                FLUSH0,
                FLUSH1,
                CNT_WR,
                DONE
        } ctrl_state_t;

        // hit count lands here after the flush walk
        localparam word_t HIT_CNT_ADDR = 32'h0000_3100;

endpackage

// File: design/cache_store.sv
module cache_store #(
        parameter int  SETS      = 8,
        parameter type payload_t = logic [31:0]
) (
        input  logic                    CLK,
        input  logic                    rst,
        input  logic [$clog2(SETS)-1:0] idx,
        input  logic                    we,
        input  payload_t                wdata,
        output payload_t                rdata
);

        payload_t entries [SETS];

        // cleared on reset so tag entries come up invalid
        always_ff @(posedge CLK) begin
                if (rst) begin
                        for (int i = 0; i < SETS; i++) begin
                                entries[i] <= '0;
                        end
                end else if (we) begin
                        entries[idx] <= wdata;
                end
        end

        // async read so hits resolve in the request cycle
        assign rdata = entries[idx];

endmodule

// File: design/dcache_lookup.sv
module dcache_lookup #(
        parameter int SETS = 8
) (
        input  logic                           CLK,
        input  logic                           rst,
        input  dcache_pkg::dp_req_t            req,
        input  dcache_pkg::tag_entry_t         tag0,
        input  dcache_pkg::tag_entry_t         tag1,
        input  logic                           lru_upd,
        output logic                           hit,
        output logic                           hit_way,
        output logic                           victim_way,
        output logic                           victim_dirty,
        output logic [dcache_pkg::TAG_W-1:0]   victim_tag
);

        logic [$clog2(SETS)-1:0] set;
        logic [SETS-1:0]         lru;
        logic                    hit0;
        logic                    hit1;

        assign set  = req.addr.idx;
        assign hit0 = tag0.valid && (tag0.tag == req.addr.tag);
        assign hit1 = tag1.valid && (tag1.tag == req.addr.tag);

        assign hit     = hit0 || hit1;
        assign hit_way = hit1;

        // lru bit names the way to evict next
        always_ff @(posedge CLK) begin
                if (rst) begin
                        lru <= '0;
                end else if (lru_upd) begin
                        lru[set] <= ~hit_way;
                end
        end

        // an empty way is always taken before the lru way
        always_comb begin
                if (!tag0.valid) begin
                        victim_way = 1'b0;
                end else if (!tag1.valid) begin
                        victim_way = 1'b1;
                end else begin
                        victim_way = lru[set];
                end
        end

        assign victim_dirty = victim_way ? tag1.dirty : tag0.dirty;
        assign victim_tag   = victim_way ? tag1.tag : tag0.tag;

endmodule

// File: design/dcache_counters.sv
module dcache_counters #(
        parameter int SETS = 8,
        parameter int WAYS = 2
) (
        input  logic                    CLK,
        input  logic                    rst,
        input  logic                    hit_inc,
        input  logic                    walk_step,
        output logic [$clog2(SETS)-1:0] frame_set,
        output logic [$clog2(WAYS)-1:0] frame_way,
        output logic                    last_frame,
        output dcache_pkg::word_t       hit_count
);

        localparam int SW = $clog2(SETS);
        localparam int WW = $clog2(WAYS);

        // way in the low bits so both ways of a set come back to back
        logic [SW+WW-1:0] frame;

        always_ff @(posedge CLK) begin
                if (rst) begin
                        frame     <= '0;
                        hit_count <= '0;
                end else begin
                        if (hit_inc) begin
                                hit_count <= hit_count + 1'b1;
                        end
                        if (walk_step) begin
                                frame <= frame + 1'b1;
                        end
                end
        end

        assign frame_set  = frame[SW+WW-1:WW];
        assign frame_way  = frame[WW-1:0];
        assign last_frame = &frame;

endmodule

// File: design/dcache_ctrl.sv
module dcache_ctrl (
        input  logic                           CLK,
        input  logic                           rst,
        input  dcache_pkg::dp_req_t            req,
        input  logic                           halt,
        input  logic                           hit,
        input  logic                           hit_way,
        input  logic                           victim_way,
        input  logic                           victim_dirty,
        input  logic [dcache_pkg::TAG_W-1:0]   victim_tag,
        input  logic [dcache_pkg::IDX_W-1:0]   frame_set,
        input  logic                           frame_way,
        input  logic                           last_frame,
        input  dcache_pkg::word_t              hit_count,
        input  dcache_pkg::tag_entry_t         frame_tag,
        input  dcache_pkg::block_t             frame_block,
        input  logic                           dwait,
        input  dcache_pkg::word_t              dload,
        output dcache_pkg::mem_req_t           mem,
        output logic                           tag_we,
        output logic                           blk_we,
        output dcache_pkg::tag_entry_t         tag_wdata,
        output dcache_pkg::block_t             blk_wdata,
        output logic                           wsel,
        output logic                           walk,
        output logic                           lru_upd,
        output logic                           hit_inc,
        output logic                           walk_step,
        output logic                           dhit,
        output logic                           flushed
);

        dcache_pkg::ctrl_state_t state;
        dcache_pkg::ctrl_state_t next_state;
        dcache_pkg::word_t       fill_word;
        logic                    filled;
        logic                    req_act;

        function automatic dcache_pkg::block_t merge(dcache_pkg::block_t b, logic blk,
                                                     dcache_pkg::word_t w);
                dcache_pkg::block_t r;
                r = b;
                if (blk) begin
                        r.word1 = w;
                end else begin
                        r.word0 = w;
                end
                return r;
        endfunction

        function automatic dcache_pkg::word_t word_addr(logic [dcache_pkg::TAG_W-1:0] tag,
                                                        logic [dcache_pkg::IDX_W-1:0] idx,
                                                        logic blk);
                return {tag, idx, blk, 2'b00};
        endfunction

        assign req_act = (req.ren || req.wen) && !halt;

        // filled marks the hit that closes a miss, which is not counted
        always_ff @(posedge CLK) begin
                if (rst) begin
                        state  <= dcache_pkg::IDLE;
                        filled <= 1'b0;
                end else begin
                        state  <= next_state;
                        filled <= (state == dcache_pkg::FILL1) && !dwait;
                end
        end

        always_ff @(posedge CLK) begin
                if (state == dcache_pkg::FILL0 && !dwait) begin
                        fill_word <= dload;
                end
        end

        assign walk = state inside {dcache_pkg::FLUSH_CHK, dcache_pkg::FLUSH0,
                                    dcache_pkg::FLUSH1};

        always_comb begin
                next_state = state;
                mem        = '0;
                tag_we     = 1'b0;
                blk_we     = 1'b0;
                tag_wdata  = frame_tag;
                blk_wdata  = frame_block;
                wsel       = walk ? frame_way : victim_way;
                lru_upd    = 1'b0;
                hit_inc    = 1'b0;
                walk_step  = 1'b0;
                dhit       = 1'b0;
                flushed    = 1'b0;
                case (state)
                dcache_pkg::IDLE: begin
                        wsel = hit_way;
                        if (halt) begin
                                next_state = dcache_pkg::FLUSH_CHK;
                        end else if (req_act && hit) begin
                                dhit    = 1'b1;
                                lru_upd = 1'b1;
                                hit_inc = !filled;
                                if (req.wen) begin
                                        tag_we          = 1'b1;
                                        blk_we          = 1'b1;
                                        tag_wdata.dirty = 1'b1;
                                        blk_wdata = merge(frame_block, req.addr.blk, req.store);
                                end
                        end else if (req_act) begin
                                next_state = victim_dirty ? dcache_pkg::WB0 : dcache_pkg::FILL0;
                        end
                end
                dcache_pkg::WB0, dcache_pkg::WB1: begin
                        mem.wen   = 1'b1;
                        mem.addr  = word_addr(victim_tag, req.addr.idx, state == dcache_pkg::WB1);
                        mem.store = (state == dcache_pkg::WB1) ? frame_block.word1
                                                               : frame_block.word0;
                        if (!dwait) begin
                                next_state = (state == dcache_pkg::WB0) ? dcache_pkg::WB1
                                                                        : dcache_pkg::FILL0;
                        end
                end
                dcache_pkg::FILL0: begin
                        mem.ren  = 1'b1;
                        mem.addr = word_addr(req.addr.tag, req.addr.idx, 1'b0);
                        if (!dwait) begin
                                next_state = dcache_pkg::FILL1;
                        end
                end
                dcache_pkg::FILL1: begin
                        mem.ren  = 1'b1;
                        mem.addr = word_addr(req.addr.tag, req.addr.idx, 1'b1);
                        if (!dwait) begin
                                tag_we          = 1'b1;
                                blk_we          = 1'b1;
                                tag_wdata.valid = 1'b1;
                                tag_wdata.dirty = req.wen;
                                tag_wdata.tag   = req.addr.tag;
                                blk_wdata.word0 = fill_word;
                                blk_wdata.word1 = dload;
                                // store word of a write miss goes in with the fill
                                if (req.wen) begin
                                        blk_wdata = merge(blk_wdata, req.addr.blk, req.store);
                                end
                                next_state = dcache_pkg::IDLE;
                        end
                end
                dcache_pkg::FLUSH_CHK: begin
                        if (frame_tag.valid && frame_tag.dirty) begin
                                next_state = dcache_pkg::FLUSH0;
                        end else begin
                                walk_step  = 1'b1;
                                next_state = last_frame ? dcache_pkg::CNT_WR
                                                        : dcache_pkg::FLUSH_CHK;
                        end
                end
                dcache_pkg::FLUSH0: begin
                        mem.wen   = 1'b1;
                        mem.addr  = word_addr(frame_tag.tag, frame_set, 1'b0);
                        mem.store = frame_block.word0;
                        if (!dwait) begin
                                next_state = dcache_pkg::FLUSH1;
                        end
                end
                dcache_pkg::FLUSH1: begin
                        mem.wen   = 1'b1;
                        mem.addr  = word_addr(frame_tag.tag, frame_set, 1'b1);
                        mem.store = frame_block.word1;
                        if (!dwait) begin
                                tag_we          = 1'b1;
                                tag_wdata.dirty = 1'b0;
                                walk_step       = 1'b1;
                                next_state      = last_frame ? dcache_pkg::CNT_WR
                                                             : dcache_pkg::FLUSH_CHK;
                        end
                end
                dcache_pkg::CNT_WR: begin
                        mem.wen   = 1'b1;
                        mem.addr  = dcache_pkg::HIT_CNT_ADDR;
                        mem.store = hit_count;
                        if (!dwait) begin
                                next_state = dcache_pkg::DONE;
                        end
                end
                dcache_pkg::DONE: begin
                        flushed = 1'b1;
                end
                default: begin
                        next_state = dcache_pkg::IDLE;
                end
                endcase
        end

endmodule

// File: design/dcache.sv
module dcache #(
        parameter int SETS = 8,
        parameter int WAYS = 2
) (
        input  logic                 CLK,
        input  logic                 rst,
        input  dcache_pkg::dp_req_t  req,
        input  logic                 halt,
        output logic                 dhit,
        output dcache_pkg::word_t    dmemload,
        output logic                 flushed,
        output dcache_pkg::mem_req_t mem,
        input  logic                 dwait,
        input  dcache_pkg::word_t    dload
);

        logic [$clog2(SETS)-1:0]       idx;
        logic [$clog2(SETS)-1:0]       frame_set;
        logic [$clog2(WAYS)-1:0]       frame_way;
        logic                          last_frame;
        dcache_pkg::word_t             hit_count;
        dcache_pkg::tag_entry_t        tags [WAYS];
        dcache_pkg::block_t            blks [WAYS];
        dcache_pkg::tag_entry_t        frame_tag;
        dcache_pkg::block_t            frame_block;
        dcache_pkg::tag_entry_t        tag_wdata;
        dcache_pkg::block_t            blk_wdata;
        logic                          tag_we;
        logic                          blk_we;
        logic                          wsel;
        logic                          walk;
        logic                          hit;
        logic                          hit_way;
        logic                          victim_way;
        logic                          victim_dirty;
        logic [dcache_pkg::TAG_W-1:0]  victim_tag;
        logic                          lru_upd;
        logic                          hit_inc;
        logic                          walk_step;

        // flush walk takes over the set index
        assign idx = walk ? frame_set : req.addr.idx;

        assign frame_tag   = tags[wsel];
        assign frame_block = blks[wsel];
        assign dmemload    = req.addr.blk ? frame_block.word1 : frame_block.word0;

        dcache_ctrl u_ctrl (.*);

        dcache_counters #(.SETS(SETS), .WAYS(WAYS)) u_counters (.*);

        dcache_lookup #(.SETS(SETS)) u_lookup (
                .CLK          (CLK),
                .rst          (rst),
                .req          (req),
                .tag0         (tags[0]),
                .tag1         (tags[1]),
                .lru_upd      (lru_upd),
                .hit          (hit),
                .hit_way      (hit_way),
                .victim_way   (victim_way),
                .victim_dirty (victim_dirty),
                .victim_tag   (victim_tag)
        );

        for (genvar w = 0; w < WAYS; w++) begin : g_way
                cache_store #(.SETS(SETS), .payload_t(dcache_pkg::tag_entry_t)) u_tags (
                        .CLK   (CLK),
                        .rst   (rst),
                        .idx   (idx),
                        .we    (tag_we && (wsel == w)),
                        .wdata (tag_wdata),
                        .rdata (tags[w])
                );

                cache_store #(.SETS(SETS), .payload_t(dcache_pkg::block_t)) u_blks (
                        .CLK   (CLK),
                        .rst   (rst),
                        .idx   (idx),
                        .we    (blk_we && (wsel == w)),
                        .wdata (blk_wdata),
                        .rdata (blks[w])
                );
        end

endmodule

// File: testbench/tb_clk_gen.sv
module tb_clk_gen #(
        parameter real PERIOD     = 10.0,
        parameter int  RST_CYCLES = 4
) (
        output logic CLK,
        output logic rst
);
        timeunit 1ns;
        timeprecision 100ps;

        initial begin
                CLK = 1'b0;
                forever #(PERIOD / 2.0) CLK = ~CLK;
        end

        initial begin
                rst = 1'b1;
                repeat (RST_CYCLES) @(posedge CLK);
                #1;
                rst = 1'b0;
        end

endmodule

// File: testbench/dcache_chk.sv
module dcache_chk (
        input logic                 CLK,
        input logic                 rst,
        input dcache_pkg::mem_req_t mem,
        input logic                 dwait,
        input logic                 flushed
);
        timeunit 1ns;
        timeprecision 100ps;

        int fail_count = 0;

        no_rw_overlap: assert property (@(posedge CLK) disable iff (rst)
                !(mem.ren && mem.wen))
                else begin
                        $error("ren and wen high in the same cycle");
                        fail_count++;
                end

        // request must hold through wait states
        req_stable: assert property (@(posedge CLK) disable iff (rst)
                (mem.ren || mem.wen) && dwait |=> $stable(mem))
                else begin
                        $error("memory request changed while dwait was high");
                        fail_count++;
                end

        quiet_after_flush: assert property (@(posedge CLK) disable iff (rst)
                flushed |-> !(mem.ren || mem.wen))
                else begin
                        $error("memory request made after flushed");
                        fail_count++;
                end

        flushed_sticky: assert property (@(posedge CLK) disable iff (rst)
                flushed |=> flushed)
                else begin
                        $error("flushed dropped after it rose");
                        fail_count++;
                end

endmodule

// File: testbench/dcache_tb.sv
module dcache_tb;
        timeunit 1ns;
        timeprecision 100ps;

        localparam int SETS           = 8;
        localparam int WAYS           = 2;
        localparam int RAND_OPS       = 60;
        localparam int POOL_SIZE      = 24;
        localparam int DIRECTED_REQS  = 10;
        localparam int TIMEOUT_CYCLES = (DIRECTED_REQS + RAND_OPS) * 40 + 200 + 10;

        // hit count address of the memory map
        localparam dcache_pkg::word_t COUNT_ADDR = 32'h0000_3100;

        typedef struct packed {
                logic              wr;
                dcache_pkg::word_t addr;
                dcache_pkg::word_t data;
        } mem_op_t;

        logic                 CLK;
        logic                 rst;
        dcache_pkg::dp_req_t  req;
        logic                 halt;
        logic                 dhit;
        dcache_pkg::word_t    dmemload;
        logic                 flushed;
        dcache_pkg::mem_req_t mem;
        logic                 dwait;
        dcache_pkg::word_t    dload;

        integer            seed = 55737;
        dcache_pkg::word_t shadow [dcache_pkg::word_t];
        dcache_pkg::word_t cpu_mem [dcache_pkg::word_t];
        mem_op_t           mem_log [$];
        int                hits_seen = 0;
        int                errors = 0;
        int                checks = 0;
        int                err_mark = 0;
        int                tests_ok = 0;
        int                tests_bad = 0;
        logic              rand_wr [RAND_OPS];
        dcache_pkg::word_t rand_addr [RAND_OPS];
        dcache_pkg::word_t rand_data [RAND_OPS];

        tb_clk_gen #(.PERIOD(10.0), .RST_CYCLES(4)) u_clk (.CLK(CLK), .rst(rst));

        dcache #(.SETS(SETS), .WAYS(WAYS)) DUT (
                .CLK      (CLK),
                .rst      (rst),
                .req      (req),
                .halt     (halt),
                .dhit     (dhit),
                .dmemload (dmemload),
                .flushed  (flushed),
                .mem      (mem),
                .dwait    (dwait),
                .dload    (dload)
        );

        bind dcache dcache_chk u_chk (.*);

        function automatic dcache_pkg::word_t make_addr(int tag, int idx, int blk);
                dcache_pkg::addr_t a;
                a          = '0;
                a.tag      = tag[dcache_pkg::TAG_W-1:0];
                a.idx      = idx[dcache_pkg::IDX_W-1:0];
                a.blk      = blk[0];
                return a;
        endfunction

        // 24 words over tags 5..7 and sets 0..3 with both block words
        function automatic dcache_pkg::word_t pool_addr(int i);
                return make_addr(5 + i / 8, (i / 2) % 4, i % 2);
        endfunction

        function automatic dcache_pkg::word_t init_word(dcache_pkg::word_t a);
                return a ^ 32'hA5A5_A5A5;
        endfunction

        function automatic dcache_pkg::word_t mem_read(dcache_pkg::word_t a);
                return shadow.exists(a) ? shadow[a] : init_word(a);
        endfunction

        function automatic dcache_pkg::word_t cpu_view(dcache_pkg::word_t a);
                return cpu_mem.exists(a) ? cpu_mem[a] : init_word(a);
        endfunction

        task automatic compare_word(input string name, input dcache_pkg::word_t got,
                                    input dcache_pkg::word_t exp);
                checks++;
                assert (got === exp) else begin
                        $display("[ERROR] %s: got %08h, expected %08h", name, got, exp);
                        errors++;
                end
        endtask

        task automatic count_equal(input string what, input int got, input int exp);
                checks++;
                assert (got == exp) else begin
                        $display("[ERROR] %s: saw %0d, expected %0d", what, got, exp);
                        errors++;
                end
        endtask

        task automatic require(input bit cond, input string what);
                checks++;
                assert (cond) else begin
                        $display("[ERROR] %s", what);
                        errors++;
                end
        endtask

        // holds one request until dhit and returns just after a rising edge
        task automatic issue(input logic wr, input dcache_pkg::word_t a,
                             input dcache_pkg::word_t d, output dcache_pkg::word_t rd,
                             output int cycles, output int words);
                int start;
                start     = mem_log.size();
                cycles    = 0;
                req.ren   = !wr;
                req.wen   = wr;
                req.addr  = a;
                req.store = d;
                @(negedge CLK);
                while (!dhit) begin
                        cycles++;
                        @(negedge CLK);
                end
                rd = dmemload;
                @(posedge CLK);
                #1;
                req   = '0;
                words = mem_log.size() - start;
                if (wr) begin
                        cpu_mem[a] = d;
                end
                if (words == 0) begin
                        hits_seen++;
                end
        endtask

        // exp_words below zero means any amount of memory traffic
        task automatic load_expect(input dcache_pkg::word_t a, input int exp_words);
                dcache_pkg::word_t rd;
                int                cycles;
                int                words;
                issue(1'b0, a, '0, rd, cycles, words);
                compare_word("dmemload", rd, cpu_view(a));
                if (exp_words >= 0) begin
                        count_equal("memory words during load", words, exp_words);
                end
                if (exp_words == 0) begin
                        count_equal("cycles to dhit", cycles, 0);
                end
        endtask

        task automatic store_expect(input dcache_pkg::word_t a, input dcache_pkg::word_t d,
                                    input int exp_words);
                dcache_pkg::word_t rd;
                int                cycles;
                int                words;
                issue(1'b1, a, d, rd, cycles, words);
                if (exp_words >= 0) begin
                        count_equal("memory words during store", words, exp_words);
                end
                if (exp_words == 0) begin
                        count_equal("cycles to dhit", cycles, 0);
                end
        endtask

        task automatic report_test(input string name);
                if (errors == err_mark) begin
                        $display("%s: ok", name);
                        tests_ok++;
                end else begin
                        $display("%s: %0d error(s)", name, errors - err_mark);
                        tests_bad++;
                end
                err_mark = errors;
        endtask

        // memory model sees completions at the negedge and redraws dwait after each rising edge
        initial begin
                mem_op_t op;
                forever begin
                        @(negedge CLK);
                        dload = mem_read(mem.addr);
                        if ((mem.ren || mem.wen) && !dwait) begin
                                op.wr   = mem.wen;
                                op.addr = mem.addr;
                                op.data = mem.wen ? mem.store : dload;
                                mem_log.push_back(op);
                                if (mem.wen) begin
                                        shadow[mem.addr] = mem.store;
                                end
                        end
                        @(posedge CLK);
                        #1;
                        dwait = ($unsigned($random(seed)) % 10) >= 6;
                end
        end

        initial begin
                repeat (TIMEOUT_CYCLES) @(posedge CLK);
                $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
                $display("Simulation failed");
                $finish;
        end

        initial begin
                int      start;
                mem_op_t op;
                int      chk_fails;
                req   = '0;
                halt  = 1'b0;
                dwait = 1'b0;
                dload = '0;
                // draw the random sequence before the memory model starts drawing
                for (int i = 0; i < RAND_OPS; i++) begin
                        rand_wr[i]   = $unsigned($random(seed)) % 2;
                        rand_addr[i] = pool_addr($unsigned($random(seed)) % POOL_SIZE);
                        rand_data[i] = $random(seed);
                end
                wait (rst == 1'b0);
                @(posedge CLK);
                #1;

                load_expect(make_addr(1, 0, 0), 2);
                load_expect(make_addr(1, 0, 1), 0);
                report_test("read miss then block hit");

                store_expect(make_addr(1, 0, 1), 32'hDEAD_BEEF, 0);
                load_expect(make_addr(1, 0, 1), 0);
                report_test("store hit then load");

                load_expect(make_addr(2, 0, 0), 2);
                start = mem_log.size();
                // tag 1 is least recent and dirty
                load_expect(make_addr(3, 0, 0), 4);
                if (mem_log.size() >= start + 2) begin
                        for (int k = 0; k < 2; k++) begin
                                op = mem_log[start + k];
                                require(op.wr, "writeback did not come before the fill");
                                compare_word("mem.addr", op.addr, make_addr(1, 0, k));
                                compare_word("mem.store", op.data, cpu_view(make_addr(1, 0, k)));
                        end
                end
                load_expect(make_addr(2, 0, 1), 0);
                report_test("fill other way and evict lru");

                store_expect(make_addr(4, 1, 1), 32'h1234_5678, 2);
                load_expect(make_addr(4, 1, 1), 0);
                load_expect(make_addr(4, 1, 0), 0);
                report_test("write miss allocate");

                for (int i = 0; i < RAND_OPS; i++) begin
                        if (rand_wr[i]) begin
                                store_expect(rand_addr[i], rand_data[i], -1);
                        end else begin
                                load_expect(rand_addr[i], -1);
                        end
                end
                report_test("random loads and stores");

                start = mem_log.size();
                halt  = 1'b1;
                @(negedge CLK);
                while (!flushed) begin
                        @(negedge CLK);
                end
                require(mem_log.size() > start, "no memory write during the flush");
                if (mem_log.size() > start) begin
                        op = mem_log[$];
                        require(op.wr, "last memory access before flushed was not a write");
                        compare_word("mem.addr", op.addr, COUNT_ADDR);
                        compare_word("mem.store", op.data, dcache_pkg::word_t'(hits_seen));
                end
                foreach (cpu_mem[addr_key]) begin
                        compare_word($sformatf("memory word at %08h", addr_key),
                                     mem_read(addr_key), cpu_mem[addr_key]);
                end
                repeat (8) begin
                        @(negedge CLK);
                        require(flushed, "flushed dropped after it rose");
                end
                report_test("halt and flush");

                chk_fails = DUT.u_chk.fail_count;
                $display("tests: %0d ok, %0d failed; checks %0d, errors %0d, assertion failures %0d",
                         tests_ok, tests_bad, checks, errors, chk_fails);
                if (errors == 0 && tests_bad == 0 && chk_fails == 0) begin
                        $display("Simulation completed successfully");
                end else begin
                        $display("Simulation failed");
                end
                $finish;
        end

endmodule

// File: tb.f
design/dcache_pkg.sv
design/cache_store.sv
design/dcache_lookup.sv
design/dcache_counters.sv
design/dcache_ctrl.sv
design/dcache.sv
testbench/tb_clk_gen.sv
testbench/dcache_chk.sv
testbench/dcache_tb.sv

// File: Bender.yml
package:
  name: dcache

sources:
  - design/dcache_pkg.sv
  - design/cache_store.sv
  - design/dcache_lookup.sv
  - design/dcache_counters.sv
  - design/dcache_ctrl.sv
  - design/dcache.sv
  - target: test
    files:
      - testbench/tb_clk_gen.sv
      - testbench/dcache_chk.sv
      - testbench/dcache_tb.sv
